/* verilog/lc4_isa_pkg.sv */
// LC4 instruction-set definitions
// Word and register index types, the kept opcodes, sub-op codes
// and the stall codes reported on the writeback trace
package lc4_isa_pkg;

   // Machine word, used for data and addresses
   localparam int WORD_W = 16;

   // Register file depth and index width
   localparam int NUM_REGS  = 8;
   localparam int REG_IDX_W = $clog2(NUM_REGS);

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // Major opcode in insn[15:12]
   // Only the supported subset is listed, all others decode as no-ops
   typedef enum logic [3:0] {
      OP_NOP   = 4'b0000,
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_e;

   // Sub-op in insn[5:3] for OP_ARITH
   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_SUB = 3'b010;

   // Sub-op in insn[5:3] for OP_LOGIC
   localparam logic [2:0] SUB_AND = 3'b000;
   localparam logic [2:0] SUB_OR  = 3'b010;
   localparam logic [2:0] SUB_XOR = 3'b011;

   // Trace stall code
   // Code 1 is left unused in a single-issue pipe
   typedef enum logic [1:0] {
      STALL_NONE   = 2'd0,
      STALL_BUBBLE = 2'd2,
      STALL_LTU    = 2'd3
   } stall_e;

endpackage

/* verilog/lc4_pipe_pkg.sv */
// LC4 pipeline payload definitions
// Decoded control, the per-stage payloads carried by the stage
// registers, the register write bundle and the writeback trace
package lc4_pipe_pkg;

   // Decoded control, travels with the instruction from D to W
   typedef struct packed {
      lc4_isa_pkg::reg_idx_t rs;
      logic                  rs_re;
      lc4_isa_pkg::reg_idx_t rt;
      logic                  rt_re;
      lc4_isa_pkg::reg_idx_t rd;
      logic                  rd_we;
      logic                  is_load;
      logic                  is_store;
   } ctrl_t;

   // Fetch to decode
   typedef struct packed {
      lc4_isa_pkg::word_t  pc;
      lc4_isa_pkg::word_t  insn;
      lc4_isa_pkg::stall_e stall;
   } d_stage_t;

   // Decode to execute, operands as read from the register file
   typedef struct packed {
      lc4_isa_pkg::word_t  pc;
      lc4_isa_pkg::word_t  insn;
      lc4_isa_pkg::stall_e stall;
      ctrl_t               ctrl;
      lc4_isa_pkg::word_t  rs_data;
      lc4_isa_pkg::word_t  rt_data;
   } x_stage_t;

   // Execute to memory
   // alu_result holds the address for loads and stores
   typedef struct packed {
      lc4_isa_pkg::word_t  pc;
      lc4_isa_pkg::word_t  insn;
      lc4_isa_pkg::stall_e stall;
      ctrl_t               ctrl;
      lc4_isa_pkg::word_t  alu_result;
      lc4_isa_pkg::word_t  rt_data;
   } m_stage_t;

   // Memory to writeback
   // dmem_data is the load data or the store data
   typedef struct packed {
      lc4_isa_pkg::word_t  pc;
      lc4_isa_pkg::word_t  insn;
      lc4_isa_pkg::stall_e stall;
      ctrl_t               ctrl;
      lc4_isa_pkg::word_t  alu_result;
      logic                dmem_we;
      lc4_isa_pkg::word_t  dmem_addr;
      lc4_isa_pkg::word_t  dmem_data;
   } w_stage_t;

   // Per-instruction record seen by the testbench
   typedef struct packed {
      lc4_isa_pkg::stall_e   stall;
      lc4_isa_pkg::word_t    pc;
      lc4_isa_pkg::word_t    insn;
      logic                  rf_we;
      lc4_isa_pkg::reg_idx_t rf_wsel;
      lc4_isa_pkg::word_t    rf_wdata;
      logic                  dmem_we;
      lc4_isa_pkg::word_t    dmem_addr;
      lc4_isa_pkg::word_t    dmem_data;
   } trace_t;

   // Register write, also the bypass source format
   typedef struct packed {
      logic                  we;
      lc4_isa_pkg::reg_idx_t sel;
      lc4_isa_pkg::word_t    data;
   } rf_write_t;

endpackage

/* verilog/lc4_pipe_reg.sv */
// Pipeline stage register
// Holds one stage payload of any type, loads when enabled and
// returns to a caller-given payload on reset
`timescale 1ns/100ps

module lc4_pipe_reg #(
   parameter type T_PAYLOAD = logic
) (
   input  logic     gwe,
   input  logic     i_rst_n,
   input  logic     i_en,
   input  T_PAYLOAD i_reset_val,
   input  T_PAYLOAD i_d,
   output T_PAYLOAD o_q
);

   // Reset value is a bubble, or the start PC for the D stage
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_q <= i_reset_val;
      end else if (i_en) begin
         o_q <= i_d;
      end
   end

endmodule

/* verilog/lc4_fetch.sv */
// Fetch stage
// Program counter with increment by one, frozen during a
// load-to-use stall so the held instruction is fetched again
`timescale 1ns/100ps

module lc4_fetch #(
   parameter lc4_isa_pkg::word_t P_PC_RESET = 16'h8200
) (
   input  logic               gwe,
   input  logic               i_rst_n,
   input  logic               i_stall,
   output lc4_isa_pkg::word_t o_pc
);

   lc4_isa_pkg::word_t pc_next;

   // No branches, so the next PC is always sequential
   assign pc_next = i_stall ? o_pc : o_pc + 16'd1;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_pc <= P_PC_RESET;
      end else begin
         o_pc <= pc_next;
      end
   end

endmodule

/* verilog/lc4_decode.sv */
// Decode stage
// Splits the instruction into register fields and control, drives
// the register file read ports and checks for a load-to-use hazard
// against the instruction in execute
`timescale 1ns/100ps

module lc4_decode (
   input  lc4_pipe_pkg::d_stage_t i_d,
   input  lc4_pipe_pkg::x_stage_t i_x,
   input  lc4_isa_pkg::word_t     i_rs_data,
   input  lc4_isa_pkg::word_t     i_rt_data,
   output lc4_isa_pkg::reg_idx_t  o_rs,
   output lc4_isa_pkg::reg_idx_t  o_rt,
   output lc4_pipe_pkg::x_stage_t o_x_next,
   output logic                   o_stall_ltu
);

   lc4_pipe_pkg::ctrl_t ctrl;
   logic                rs_hit;
   logic                rt_hit;

   always_comb begin
      ctrl = '0;
      case (lc4_isa_pkg::opcode_e'(i_d.insn[15:12]))
         lc4_isa_pkg::OP_ARITH, lc4_isa_pkg::OP_LOGIC: begin
            ctrl.rd    = i_d.insn[11:9];
            ctrl.rd_we = 1'b1;
            ctrl.rs    = i_d.insn[8:6];
            ctrl.rs_re = 1'b1;
            // insn[5] set means immediate form, no rt
            ctrl.rt    = i_d.insn[2:0];
            ctrl.rt_re = ~i_d.insn[5];
         end
         lc4_isa_pkg::OP_LDR: begin
            ctrl.rd      = i_d.insn[11:9];
            ctrl.rd_we   = 1'b1;
            ctrl.rs      = i_d.insn[8:6];
            ctrl.rs_re   = 1'b1;
            ctrl.is_load = 1'b1;
         end
         lc4_isa_pkg::OP_STR: begin
            // Store data register sits in the rd field
            ctrl.rt       = i_d.insn[11:9];
            ctrl.rt_re    = 1'b1;
            ctrl.rs       = i_d.insn[8:6];
            ctrl.rs_re    = 1'b1;
            ctrl.is_store = 1'b1;
         end
         lc4_isa_pkg::OP_CONST: begin
            ctrl.rd    = i_d.insn[11:9];
            ctrl.rd_we = 1'b1;
         end
         lc4_isa_pkg::OP_NOP: begin
            // Never-taken branch form only, nothing to set
         end
         default: begin
            // Unsupported opcodes retire with no side effects
         end
      endcase
   end

   assign o_rs = ctrl.rs;
   assign o_rt = ctrl.rt;

   // Load in X whose result D needs right away
   // Store rt is left to the W to M bypass
   assign rs_hit = ctrl.rs_re && (ctrl.rs == i_x.ctrl.rd);
   assign rt_hit = ctrl.rt_re && !ctrl.is_store && (ctrl.rt == i_x.ctrl.rd);
   assign o_stall_ltu = i_x.ctrl.is_load && i_x.ctrl.rd_we && (rs_hit || rt_hit);

   // Bubble keeps the PC of the held instruction
   always_comb begin
      if (o_stall_ltu) begin
         o_x_next = '{pc: i_d.pc, insn: '0, stall: lc4_isa_pkg::STALL_LTU,
                      ctrl: '0, rs_data: '0, rt_data: '0};
      end else begin
         o_x_next = '{pc: i_d.pc, insn: i_d.insn, stall: i_d.stall,
                      ctrl: ctrl, rs_data: i_rs_data, rt_data: i_rt_data};
      end
   end

endmodule

/* verilog/lc4_regfile.sv */
// Register file
// Eight 16-bit registers with two combinational read ports and one
// write port, a read of the register being written sees the new value
`timescale 1ns/100ps

module lc4_regfile (
   input  logic                   gwe,
   input  logic                   i_rst_n,
   input  lc4_isa_pkg::reg_idx_t  i_rs,
   input  lc4_isa_pkg::reg_idx_t  i_rt,
   input  lc4_pipe_pkg::rf_write_t i_wr,
   output lc4_isa_pkg::word_t     o_rs_data,
   output lc4_isa_pkg::word_t     o_rt_data
);

   lc4_isa_pkg::word_t regs [lc4_isa_pkg::NUM_REGS];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < lc4_isa_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr.we) begin
         regs[i_wr.sel] <= i_wr.data;
      end
   end

   // Write-before-read, covers the W to D distance
   assign o_rs_data = (i_wr.we && i_wr.sel == i_rs) ? i_wr.data : regs[i_rs];
   assign o_rt_data = (i_wr.we && i_wr.sel == i_rt) ? i_wr.data : regs[i_rt];

endmodule

/* verilog/lc4_execute.sv */
// Execute stage
// Picks each operand from the M stage, the W stage or the register
// read, then runs the subset ALU and the load/store address add
`timescale 1ns/100ps

module lc4_execute (
   input  lc4_pipe_pkg::x_stage_t  i_x,
   input  lc4_pipe_pkg::rf_write_t i_m_wr,
   input  lc4_pipe_pkg::rf_write_t i_w_wr,
   output lc4_pipe_pkg::m_stage_t  o_m_next
);

   lc4_isa_pkg::word_t rs_val;
   lc4_isa_pkg::word_t rt_val;
   lc4_isa_pkg::word_t imm5;
   lc4_isa_pkg::word_t imm6;
   lc4_isa_pkg::word_t imm9;
   lc4_isa_pkg::word_t alu;

   // Youngest producer wins, M ahead of W ahead of the register read
   function automatic lc4_isa_pkg::word_t bypass(
      input lc4_isa_pkg::reg_idx_t   idx,
      input lc4_isa_pkg::word_t      rf_val,
      input lc4_pipe_pkg::rf_write_t m_wr,
      input lc4_pipe_pkg::rf_write_t w_wr
   );
      if (m_wr.we && m_wr.sel == idx)
         return m_wr.data;
      else if (w_wr.we && w_wr.sel == idx)
         return w_wr.data;
      else
         return rf_val;
   endfunction

   assign rs_val = bypass(i_x.ctrl.rs, i_x.rs_data, i_m_wr, i_w_wr);
   assign rt_val = bypass(i_x.ctrl.rt, i_x.rt_data, i_m_wr, i_w_wr);

   // Sign-extended immediates
   assign imm5 = {{11{i_x.insn[4]}}, i_x.insn[4:0]};
   assign imm6 = {{10{i_x.insn[5]}}, i_x.insn[5:0]};
   assign imm9 = {{7{i_x.insn[8]}}, i_x.insn[8:0]};

   always_comb begin
      alu = '0;
      case (lc4_isa_pkg::opcode_e'(i_x.insn[15:12]))
         lc4_isa_pkg::OP_ARITH: begin
            if (i_x.insn[5])
               alu = rs_val + imm5;
            else if (i_x.insn[5:3] == lc4_isa_pkg::SUB_ADD)
               alu = rs_val + rt_val;
            else if (i_x.insn[5:3] == lc4_isa_pkg::SUB_SUB)
               alu = rs_val - rt_val;
         end
         lc4_isa_pkg::OP_LOGIC: begin
            case (i_x.insn[5:3])
               lc4_isa_pkg::SUB_AND: alu = rs_val & rt_val;
               lc4_isa_pkg::SUB_OR:  alu = rs_val | rt_val;
               lc4_isa_pkg::SUB_XOR: alu = rs_val ^ rt_val;
               default:              alu = '0;
            endcase
         end
         lc4_isa_pkg::OP_CONST: alu = imm9;
         // Effective address for both memory ops
         lc4_isa_pkg::OP_LDR, lc4_isa_pkg::OP_STR: alu = rs_val + imm6;
         default: alu = '0;
      endcase
   end

   // Store data leaves with the bypassed rt
   assign o_m_next = '{pc: i_x.pc, insn: i_x.insn, stall: i_x.stall, ctrl: i_x.ctrl,
                       alu_result: alu, rt_data: rt_val};

endmodule

/* verilog/lc4_memory.sv */
// Memory stage
// Drives the data memory port, patches store data from writeback
// and offers the M-stage result to the execute bypass
`timescale 1ns/100ps

module lc4_memory (
   input  lc4_pipe_pkg::m_stage_t  i_m,
   input  lc4_pipe_pkg::rf_write_t i_w_wr,
   input  lc4_isa_pkg::word_t      i_dmem_rdata,
   output lc4_isa_pkg::word_t      o_dmem_addr,
   output logic                    o_dmem_we,
   output lc4_isa_pkg::word_t      o_dmem_wdata,
   output lc4_pipe_pkg::w_stage_t  o_w_next,
   output lc4_pipe_pkg::rf_write_t o_m_wr
);

   lc4_isa_pkg::word_t store_data;
   lc4_isa_pkg::word_t mem_data;
   logic               mem_op;

   assign mem_op = i_m.ctrl.is_load | i_m.ctrl.is_store;

   // W to M bypass, a load right ahead of a store of its result
   assign store_data = (i_w_wr.we && i_w_wr.sel == i_m.ctrl.rt) ? i_w_wr.data : i_m.rt_data;

   assign o_dmem_we    = i_m.ctrl.is_store;
   assign o_dmem_addr  = mem_op ? i_m.alu_result : '0;
   assign o_dmem_wdata = i_m.ctrl.is_store ? store_data : '0;

   // Load data or store data, zero for other instructions
   assign mem_data = i_m.ctrl.is_load ? i_dmem_rdata : o_dmem_wdata;

   assign o_w_next = '{pc: i_m.pc, insn: i_m.insn, stall: i_m.stall, ctrl: i_m.ctrl,
                       alu_result: i_m.alu_result, dmem_we: o_dmem_we,
                       dmem_addr: o_dmem_addr, dmem_data: mem_data};

   // Load data is not ready here, so a load is never forwarded from M
   assign o_m_wr = '{we: i_m.ctrl.rd_we & ~i_m.ctrl.is_load, sel: i_m.ctrl.rd,
                     data: i_m.alu_result};

endmodule

/* verilog/lc4_writeback.sv */
// Writeback stage
// Chooses load data or the ALU result, drives the register write
// and the bypass source, and assembles the trace record
`timescale 1ns/100ps

module lc4_writeback (
   input  lc4_pipe_pkg::w_stage_t  i_w,
   output lc4_pipe_pkg::rf_write_t o_rf_wr,
   output lc4_pipe_pkg::trace_t    o_trace
);

   lc4_isa_pkg::word_t wdata;

   assign wdata = i_w.ctrl.is_load ? i_w.dmem_data : i_w.alu_result;

   assign o_rf_wr = '{we: i_w.ctrl.rd_we, sel: i_w.ctrl.rd, data: wdata};

   // Bubbles show rf_we and dmem_we low through their cleared control
   assign o_trace = '{stall: i_w.stall, pc: i_w.pc, insn: i_w.insn,
                      rf_we: i_w.ctrl.rd_we, rf_wsel: i_w.ctrl.rd, rf_wdata: wdata,
                      dmem_we: i_w.dmem_we, dmem_addr: i_w.dmem_addr,
                      dmem_data: i_w.dmem_data};

endmodule

/* verilog/lc4_core.sv */
// LC4 five-stage pipelined core
// Fetch, decode, execute, memory and writeback with MX, WX and WM
// bypassing and a one-cycle load-to-use stall
// Instruction and data memories are combinational, outside the core
`timescale 1ns/100ps

module lc4_core #(
   parameter lc4_isa_pkg::word_t P_PC_RESET = 16'h8200
) (
   input  logic                 gwe,
   input  logic                 i_rst_n,
   output lc4_isa_pkg::word_t   o_imem_addr,
   input  lc4_isa_pkg::word_t   i_imem_data,
   output lc4_isa_pkg::word_t   o_dmem_addr,
   output logic                 o_dmem_we,
   output lc4_isa_pkg::word_t   o_dmem_wdata,
   input  lc4_isa_pkg::word_t   i_dmem_rdata,
   output lc4_pipe_pkg::trace_t o_trace
);

   lc4_isa_pkg::word_t      pc;
   logic                    stall_ltu;
   lc4_pipe_pkg::d_stage_t  d_next, d_q, d_reset;
   lc4_pipe_pkg::x_stage_t  x_next, x_q, x_reset;
   lc4_pipe_pkg::m_stage_t  m_next, m_q, m_reset;
   lc4_pipe_pkg::w_stage_t  w_next, w_q, w_reset;
   lc4_isa_pkg::reg_idx_t   rs_idx, rt_idx;
   lc4_isa_pkg::word_t      rs_data, rt_data;
   lc4_pipe_pkg::rf_write_t m_wr, w_wr;

   // Reset payloads, every stage starts as a bubble
   assign d_reset = '{pc: P_PC_RESET, insn: '0, stall: lc4_isa_pkg::STALL_BUBBLE};
   assign x_reset = '{pc: '0, insn: '0, stall: lc4_isa_pkg::STALL_BUBBLE,
                      ctrl: '0, rs_data: '0, rt_data: '0};
   assign m_reset = '{pc: '0, insn: '0, stall: lc4_isa_pkg::STALL_BUBBLE,
                      ctrl: '0, alu_result: '0, rt_data: '0};
   assign w_reset = '{pc: '0, insn: '0, stall: lc4_isa_pkg::STALL_BUBBLE, ctrl: '0,
                      alu_result: '0, dmem_we: 1'b0, dmem_addr: '0, dmem_data: '0};

   // Fetch
   lc4_fetch #(.P_PC_RESET(P_PC_RESET)) lc4_fetch_inst (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_stall(stall_ltu), .o_pc(pc)
   );

   assign o_imem_addr = pc;
   assign d_next = '{pc: pc, insn: i_imem_data, stall: lc4_isa_pkg::STALL_NONE};

   // F to D, held together with the PC on a stall
   lc4_pipe_reg #(.T_PAYLOAD(lc4_pipe_pkg::d_stage_t)) d_reg_inst (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_en(~stall_ltu),
      .i_reset_val(d_reset), .i_d(d_next), .o_q(d_q)
   );

   lc4_decode lc4_decode_inst (
      .i_d(d_q), .i_x(x_q), .i_rs_data(rs_data), .i_rt_data(rt_data),
      .o_rs(rs_idx), .o_rt(rt_idx), .o_x_next(x_next), .o_stall_ltu(stall_ltu)
   );

   lc4_regfile lc4_regfile_inst (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_rs(rs_idx), .i_rt(rt_idx), .i_wr(w_wr),
      .o_rs_data(rs_data), .o_rt_data(rt_data)
   );

   // D to X
   lc4_pipe_reg #(.T_PAYLOAD(lc4_pipe_pkg::x_stage_t)) x_reg_inst (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_en(1'b1),
      .i_reset_val(x_reset), .i_d(x_next), .o_q(x_q)
   );

   lc4_execute lc4_execute_inst (
      .i_x(x_q), .i_m_wr(m_wr), .i_w_wr(w_wr), .o_m_next(m_next)
   );

   // X to M
   lc4_pipe_reg #(.T_PAYLOAD(lc4_pipe_pkg::m_stage_t)) m_reg_inst (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_en(1'b1),
      .i_reset_val(m_reset), .i_d(m_next), .o_q(m_q)
   );

   lc4_memory lc4_memory_inst (
      .i_m(m_q), .i_w_wr(w_wr), .i_dmem_rdata(i_dmem_rdata),
      .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_wdata(o_dmem_wdata),
      .o_w_next(w_next), .o_m_wr(m_wr)
   );

   // M to W, the trace is decoded straight from this register
   lc4_pipe_reg #(.T_PAYLOAD(lc4_pipe_pkg::w_stage_t)) w_reg_inst (
      .gwe(gwe), .i_rst_n(i_rst_n), .i_en(1'b1),
      .i_reset_val(w_reset), .i_d(w_next), .o_q(w_q)
   );

   lc4_writeback lc4_writeback_inst (
      .i_w(w_q), .o_rf_wr(w_wr), .o_trace(o_trace)
   );

endmodule

/* verif/tb_lc4_programs.svh */
// LC4 core test programs and expected writeback trace
// PROG holds the instruction words of all tests back to back
// Expected row columns are stall, program index, rf_we, rf_wsel,
// rf_wdata, dmem_we, dmem_addr, dmem_data
// The program index also gives the pc, start address plus index
`ifndef TB_LC4_PROGRAMS_SVH
`define TB_LC4_PROGRAMS_SVH

localparam int NUM_TESTS = 4;
localparam int NUM_PROG  = 31;
localparam int NUM_EXP   = 32;

string test_name [NUM_TESTS] = '{"alu_bypass", "rf_bypass", "load_use", "store_after_load"};

localparam int PROG_START [NUM_TESTS] = '{0, 9, 17, 25};
localparam int PROG_LEN   [NUM_TESTS] = '{9, 8, 8, 6};
localparam int EXP_START  [NUM_TESTS] = '{0, 9, 17, 26};
localparam int EXP_LEN    [NUM_TESTS] = '{9, 8, 9, 6};

localparam lc4_isa_pkg::word_t PROG [NUM_PROG] = '{
   // alu_bypass, back-to-back dependent CONST, ADD, SUB, ADDI, XOR, OR, AND
   16'h9205, 16'h95FD, 16'h1642, 16'h18D1, 16'h1B27, 16'h5D5A, 16'h5F91, 16'h51C5,
   16'h1270,
   // rf_bypass, consumers three slots after their producers
   16'h9264, 16'h0000, 16'h0000, 16'h1461, 16'h96FF, 16'h0000, 16'h0000, 16'h18D2,
   // load_use, store then load and dependent or independent uses
   16'h9220, 16'h9477, 16'h7443, 16'h6643, 16'h18E1, 16'h6A43, 16'h1C62, 16'h1F46,
   // store_after_load, store data taken from the load just ahead
   16'h9240, 16'h95FE, 16'h7440, 16'h6640, 16'h7645, 16'h6845
};

exp_t exp_tab [NUM_EXP] = '{
   // CONST R1,5 / CONST R2,-3 / ADD R3,R1,R2 / SUB R4,R3,R1
   '{REAL, 8'd0, 1'b1, 3'd1, 16'h0005, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd1, 1'b1, 3'd2, 16'hFFFD, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd2, 1'b1, 3'd3, 16'h0002, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd3, 1'b1, 3'd4, 16'hFFFD, 1'b0, 16'h0000, 16'h0000},
   // ADD R5,R4,#7 / XOR R6,R5,R2 / OR R7,R6,R1 / AND R0,R7,R5 / ADD R1,R1,#-16
   '{REAL, 8'd4, 1'b1, 3'd5, 16'h0004, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd5, 1'b1, 3'd6, 16'hFFF9, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd6, 1'b1, 3'd7, 16'hFFFD, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd7, 1'b1, 3'd0, 16'h0004, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd8, 1'b1, 3'd1, 16'hFFF5, 1'b0, 16'h0000, 16'h0000},
   // CONST R1,100 / NOP / NOP / ADD R2,R1,#1
   '{REAL, 8'd0, 1'b1, 3'd1, 16'h0064, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd1, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd2, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd3, 1'b1, 3'd2, 16'h0065, 1'b0, 16'h0000, 16'h0000},
   // CONST R3,255 / NOP / NOP / SUB R4,R3,R2
   '{REAL, 8'd4, 1'b1, 3'd3, 16'h00FF, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd5, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd6, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd7, 1'b1, 3'd4, 16'h009A, 1'b0, 16'h0000, 16'h0000},
   // CONST R1,20h / CONST R2,77h / STR R2,R1,#3 / LDR R3,R1,#3
   '{REAL, 8'd0, 1'b1, 3'd1, 16'h0020, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd1, 1'b1, 3'd2, 16'h0077, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd2, 1'b0, 3'd0, 16'h0000, 1'b1, 16'h0023, 16'h0077},
   '{REAL, 8'd3, 1'b1, 3'd3, 16'h0077, 1'b0, 16'h0000, 16'h0000},
   // Bubble ahead of ADD R4,R3,#1, it carries the held pc
   '{LTU,  8'd4, 1'b0, 3'd0, 16'h0000, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd4, 1'b1, 3'd4, 16'h0078, 1'b0, 16'h0000, 16'h0000},
   // LDR R5,R1,#3 then unrelated ADD R6,R1,#2, no stall / ADD R7,R5,R6
   '{REAL, 8'd5, 1'b1, 3'd5, 16'h0077, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd6, 1'b1, 3'd6, 16'h0022, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd7, 1'b1, 3'd7, 16'h0099, 1'b0, 16'h0000, 16'h0000},
   // CONST R1,40h / CONST R2,-2 / STR R2,R1,#0 / LDR R3,R1,#0
   '{REAL, 8'd0, 1'b1, 3'd1, 16'h0040, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd1, 1'b1, 3'd2, 16'hFFFE, 1'b0, 16'h0000, 16'h0000},
   '{REAL, 8'd2, 1'b0, 3'd0, 16'h0000, 1'b1, 16'h0040, 16'hFFFE},
   '{REAL, 8'd3, 1'b1, 3'd3, 16'hFFFE, 1'b0, 16'h0000, 16'h0000},
   // STR R3,R1,#5 gets the load data from W / LDR R4,R1,#5 reads it back
   '{REAL, 8'd4, 1'b0, 3'd0, 16'h0000, 1'b1, 16'h0045, 16'hFFFE},
   '{REAL, 8'd5, 1'b1, 3'd4, 16'hFFFE, 1'b0, 16'h0000, 16'h0000}
};

`endif

/* verif/tb_lc4_core.sv */
// Testbench for the LC4 pipelined core
// Models combinational instruction and data memories, runs each table
// program after a reset and compares the writeback trace in order
`timescale 1ns/100ps

module tb_lc4_core;

   localparam lc4_isa_pkg::word_t PC_RESET = 16'h8200;
   localparam int RESET_CYCLES = 5;
   // Samples after reset release before the first real trace entry
   localparam int FIRST_REAL = 4;
   localparam lc4_isa_pkg::stall_e REAL = lc4_isa_pkg::STALL_NONE;
   localparam lc4_isa_pkg::stall_e LTU  = lc4_isa_pkg::STALL_LTU;

   // One expected trace entry
   typedef struct packed {
      lc4_isa_pkg::stall_e   stall;
      logic [7:0]            idx;
      logic                  rf_we;
      lc4_isa_pkg::reg_idx_t sel;
      lc4_isa_pkg::word_t    wdata;
      logic                  dmem_we;
      lc4_isa_pkg::word_t    daddr;
      lc4_isa_pkg::word_t    ddata;
   } exp_t;

   `include "tb_lc4_programs.svh"

   logic                 gwe;
   logic                 i_rst_n;
   lc4_isa_pkg::word_t   imem_addr;
   lc4_isa_pkg::word_t   imem_data;
   lc4_isa_pkg::word_t   imem_off;
   lc4_isa_pkg::word_t   dmem_addr;
   lc4_isa_pkg::word_t   dmem_wdata;
   lc4_isa_pkg::word_t   dmem_rdata;
   logic                 dmem_we;
   lc4_pipe_pkg::trace_t trace;

   lc4_isa_pkg::word_t imem [256];
   lc4_isa_pkg::word_t dmem [256];

   int errors;
   int checks;
   int failed_tests;
   int cycle_count = 0;
   int cycle_limit;

   lc4_core #(.P_PC_RESET(PC_RESET)) lc4_core_inst (
      .gwe(gwe), .i_rst_n(i_rst_n),
      .o_imem_addr(imem_addr), .i_imem_data(imem_data),
      .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_wdata(dmem_wdata),
      .i_dmem_rdata(dmem_rdata), .o_trace(trace)
   );

   initial begin
      gwe = 1'b0;
      forever #4 gwe = ~gwe;
   end

   // Instruction memory starts at the reset PC and reads NOPs outside the program
   assign imem_off  = imem_addr - PC_RESET;
   assign imem_data = (imem_off < 16'd256) ? imem[imem_off[7:0]] : '0;

   // Data memory read in the same cycle and written at the edge
   assign dmem_rdata = dmem[dmem_addr[7:0]];

   always @(posedge gwe) begin
      if (dmem_we) begin
         dmem[dmem_addr[7:0]] <= dmem_wdata;
      end
   end

   // Watchdog on total cycles
   always @(posedge gwe) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Timeout, run went past %0d cycles without finishing", cycle_limit);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic compare_field(input string test, input string field, input int entry,
                                input logic [15:0] exp_val, input logic [15:0] act_val);
      checks++;
      assert (act_val === exp_val) else begin
         $display("ERR %s entry %0d %s: expected %h actual %h",
                  test, entry, field, exp_val, act_val);
         errors++;
      end
   endtask

   task automatic check_entry(input int t, input int e, input lc4_pipe_pkg::trace_t tr);
      exp_t               x;
      lc4_isa_pkg::word_t exp_insn;
      x = exp_tab[EXP_START[t] + e];
      // Load-to-use bubble shows an all-zero instruction
      exp_insn = (x.stall == LTU) ? 16'h0000 : PROG[PROG_START[t] + x.idx];
      compare_field(test_name[t], "stall", e, 16'(x.stall), 16'(tr.stall));
      compare_field(test_name[t], "pc", e, PC_RESET + 16'(x.idx), tr.pc);
      compare_field(test_name[t], "insn", e, exp_insn, tr.insn);
      compare_field(test_name[t], "rf_we", e, 16'(x.rf_we), 16'(tr.rf_we));
      if (x.rf_we) begin
         compare_field(test_name[t], "rf_wsel", e, 16'(x.sel), 16'(tr.rf_wsel));
         compare_field(test_name[t], "rf_wdata", e, x.wdata, tr.rf_wdata);
      end
      compare_field(test_name[t], "dmem_we", e, 16'(x.dmem_we), 16'(tr.dmem_we));
      if (x.dmem_we) begin
         compare_field(test_name[t], "dmem_addr", e, x.daddr, tr.dmem_addr);
         compare_field(test_name[t], "dmem_data", e, x.ddata, tr.dmem_data);
      end
   endtask

   // Holds reset for five cycles while the program is loaded
   task automatic apply_reset(input int t);
      @(posedge gwe);
      i_rst_n <= 1'b0;
      for (int i = 0; i < 256; i++) begin
         if (i < PROG_LEN[t])
            imem[i] = PROG[PROG_START[t] + i];
         else
            imem[i] = '0;
      end
      repeat (RESET_CYCLES) begin
         @(negedge gwe);
         checks++;
         assert (!dmem_we && trace.stall == lc4_isa_pkg::STALL_BUBBLE) else begin
            $display("Test %s: memory write or real trace entry seen during reset",
                     test_name[t]);
            errors++;
         end
      end
      @(posedge gwe);
      i_rst_n <= 1'b1;
   endtask

   // Walks the trace until every expected entry has been seen
   task automatic follow_trace(input int t);
      int                   n;
      int                   got;
      lc4_pipe_pkg::trace_t tr;
      n = 0;
      got = 0;
      while (got < EXP_LEN[t]) begin
         @(negedge gwe);
         tr = trace;
         if (tr.stall == lc4_isa_pkg::STALL_BUBBLE) begin
            // Reset bubbles only lead the program and never write
            checks++;
            assert (got == 0 && !tr.rf_we && !tr.dmem_we) else begin
               $display("Test %s: unexpected reset bubble or bubble with a write at entry %0d",
                        test_name[t], got);
               errors++;
            end
         end else begin
            if (got == 0) begin
               checks++;
               assert (n == FIRST_REAL) else begin
                  $display("Test %s: first real trace entry came %0d cycles after reset",
                           test_name[t], n);
                  errors++;
               end
            end
            check_entry(t, got, tr);
            got++;
         end
         n++;
      end
   endtask

   initial begin
      int errs_before;
      i_rst_n <= 1'b0;
      errors = 0;
      checks = 0;
      failed_tests = 0;
      // Random data memory contents and an empty instruction memory
      void'($urandom(28));
      for (int i = 0; i < 256; i++) begin
         dmem[i] = 16'($urandom);
         imem[i] = '0;
      end
      cycle_limit = 0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         cycle_limit += PROG_LEN[t] * 2 + 20;
      end
      for (int t = 0; t < NUM_TESTS; t++) begin
         errs_before = errors;
         apply_reset(t);
         follow_trace(t);
         if (errors == errs_before) begin
            $display("PASS %s, %0d trace entries", test_name[t], EXP_LEN[t]);
         end else begin
            failed_tests++;
            $display("FAIL %s, %0d errors", test_name[t], errors - errs_before);
         end
      end
      $display("Tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
               NUM_TESTS, NUM_TESTS - failed_tests, failed_tests, checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* project.f */
verilog/lc4_isa_pkg.sv
verilog/lc4_pipe_pkg.sv
verilog/lc4_pipe_reg.sv
verilog/lc4_fetch.sv
verilog/lc4_decode.sv
verilog/lc4_regfile.sv
verilog/lc4_execute.sv
verilog/lc4_memory.sv
verilog/lc4_writeback.sv
verilog/lc4_core.sv
+incdir+verif
verif/tb_lc4_core.sv
